// ==== project.f ====
src/router_pkg.sv
src/stream_selector.sv
src/frame_accumulator.sv
src/result_merger.sv
src/frame_sum_router.sv
tests/clock_gen.sv
tests/tb_frame_sum_router.sv

// ==== src/frame_accumulator.sv ====
// One accumulator lane of the frame-summing router.
// Samples of the open frame are added into a running sum and count.
// The last sample of a frame moves the totals into a result register
// that is held, tagged with the lane number, until the merger takes it.
// A lane stalls its input while an older result is still waiting.

`timescale 1ns/1ps

module frame_accumulator (
    input  logic                     clock,
    input  logic                     rst_n,
    input  router_pkg::sample_beat_t sample_beat,
    input  logic                     sample_valid,
    output logic                     sample_ready,
    input  router_pkg::lane_t        lane_id,
    output router_pkg::sum_beat_t    result,
    output logic                     result_valid,
    input  logic                     result_ready
);

    router_pkg::sum_t   acc_sum;
    router_pkg::count_t acc_count;
    router_pkg::sum_t   next_sum;
    router_pkg::count_t next_count;
    logic               accept;
    logic               close_frame;

    // Stall while a result is pending and the merger is not taking it
    assign sample_ready = !result_valid || result_ready;
    assign accept       = sample_valid && sample_ready;
    assign close_frame  = accept && sample_beat.last;

    // Totals including the sample presented this cycle
    assign next_sum   = acc_sum + router_pkg::sum_t'(sample_beat.data);
    assign next_count = acc_count + router_pkg::count_t'(1);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            acc_sum      <= '0;
            acc_count    <= '0;
            result_valid <= 1'b0;
        end else begin
            if (close_frame) begin
                // Start the next frame from zero
                acc_sum      <= '0;
                acc_count    <= '0;
                result_valid <= 1'b1;
            end else begin
                if (accept) begin
                    acc_sum   <= next_sum;
                    acc_count <= next_count;
                end
                if (result_valid && result_ready) begin
                    result_valid <= 1'b0;
                end
            end
        end
    end

    // The result payload is only written when a frame closes
    always_ff @(posedge clock) begin
        if (close_frame) begin
            result.sum   <= next_sum;
            result.count <= next_count;
            result.lane  <= lane_id;
        end
    end

    // A pending result must not change or vanish before it is taken
    a_result_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result)
    ) else $error("lane %0d result changed while stalled", lane_id);

endmodule

// ==== src/frame_sum_router.sv ====
// Top level of the frame-summing stream router.
// Samples enter on one valid/ready stream, are steered to a lane by
// destination, summed per frame, and the per-frame results leave on a
// single stream tagged with the lane that produced them.

`timescale 1ns/1ps

module frame_sum_router (
    input  logic                     clock,
    input  logic                     rst_n,
    input  router_pkg::sample_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output router_pkg::sum_beat_t    out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    // Selector to lanes, one beat shared by all lanes
    router_pkg::sample_beat_t         lane_beat;
    logic [router_pkg::NUM_LANES-1:0] lane_valid;
    logic [router_pkg::NUM_LANES-1:0] lane_ready;

    // Lanes to merger
    router_pkg::sum_beat_t            result [router_pkg::NUM_LANES];
    logic [router_pkg::NUM_LANES-1:0] result_valid;
    logic [router_pkg::NUM_LANES-1:0] result_ready;

    stream_selector stream_selector_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_beat  (lane_beat),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

    for (genvar i = 0; i < router_pkg::NUM_LANES; i++) begin : g_lane
        frame_accumulator frame_accumulator_i (
            .clock        (clock),
            .rst_n        (rst_n),
            .sample_beat  (lane_beat),
            .sample_valid (lane_valid[i]),
            .sample_ready (lane_ready[i]),
            .lane_id      (router_pkg::lane_t'(i)),
            .result       (result[i]),
            .result_valid (result_valid[i]),
            .result_ready (result_ready[i])
        );
    end

    result_merger result_merger_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

// ==== src/result_merger.sv ====
// Round-robin merger of lane results onto one output stream.
// A registered grant pointer names the single lane offered ready, so
// ready never depends on that lane's own valid. After each transfer
// the pointer moves to the next requesting lane after the one served.
// The chosen result is captured in one output register.

`timescale 1ns/1ps

module result_merger (
    input  logic                             clock,
    input  logic                             rst_n,
    input  router_pkg::sum_beat_t            result [router_pkg::NUM_LANES],
    input  logic [router_pkg::NUM_LANES-1:0] result_valid,
    output logic [router_pkg::NUM_LANES-1:0] result_ready,
    output router_pkg::sum_beat_t            out_beat,
    output logic                             out_valid,
    input  logic                             out_ready
);

    router_pkg::lane_t grant_ptr;
    router_pkg::lane_t next_ptr;
    logic              out_free;
    logic              grant_valid;
    logic              transfer;

    // Output register can accept when empty or being drained
    assign out_free    = !out_valid || out_ready;
    assign grant_valid = result_valid[grant_ptr];
    assign transfer    = out_free && grant_valid;

    always_comb begin
        result_ready = '0;
        if (out_free) begin
            result_ready[grant_ptr] = 1'b1;
        end
    end

    // Search starts one past the pointer, and the pointer itself comes last
    always_comb begin
        next_ptr = grant_ptr;
        for (int k = router_pkg::NUM_LANES; k >= 1; k--) begin
            if (result_valid[(int'(grant_ptr) + k) % router_pkg::NUM_LANES]) begin
                next_ptr = router_pkg::lane_t'((int'(grant_ptr) + k) % router_pkg::NUM_LANES);
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            grant_ptr <= '0;
            out_valid <= 1'b0;
        end else begin
            // Hold the pointer only while its lane is waiting on a full output
            if (!grant_valid || out_free) begin
                grant_ptr <= next_ptr;
            end
            if (out_free) begin
                out_valid <= grant_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (transfer) begin
            out_beat <= result[grant_ptr];
        end
    end

    // Only one lane may ever see ready in a given cycle
    a_ready_onehot: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0(result_ready)
    ) else $error("result_ready is not one-hot: %b", result_ready);

endmodule

// ==== src/router_pkg.sv ====
// Shared sizes and beat types for the frame-summing stream router.
// Compiled ahead of the RTL and the testbench, which both take the
// widths, the lane count and the beat structs from here.

package router_pkg;

    // Lane count must stay a power of two that fits in LANE_W bits
    localparam int NUM_LANES = 4;
    localparam int DEST_W    = 3;
    localparam int LANE_W    = 2;
    localparam int SAMPLE_W  = 16;
    localparam int SUM_W     = 24;
    localparam int COUNT_W   = 8;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [DEST_W-1:0]   dest_t;
    typedef logic [LANE_W-1:0]   lane_t;

    // Wide enough for 255 full-scale samples without overflow
    typedef logic [SUM_W-1:0]    sum_t;
    typedef logic [COUNT_W-1:0]  count_t;

    // One input sample with its routing tag and end-of-frame flag
    typedef struct packed {
        sample_t data;
        dest_t   dest;
        logic    last;
    } sample_beat_t;

    // One finished frame as reported by a lane
    typedef struct packed {
        sum_t   sum;
        count_t count;
        lane_t  lane;
    } sum_beat_t;

endpackage

// ==== src/stream_selector.sv ====
// Registered one-to-NUM_LANES stream selector.
// Each accepted sample is steered to the lane named by its destination
// field and held in a single output register until that lane takes it.
// Samples whose destination has no lane are accepted and dropped.

`timescale 1ns/1ps

module stream_selector (
    input  logic                             clock,
    input  logic                             rst_n,
    input  router_pkg::sample_beat_t         in_beat,
    input  logic                             in_valid,
    output logic                             in_ready,
    output router_pkg::sample_beat_t         lane_beat,
    output logic [router_pkg::NUM_LANES-1:0] lane_valid,
    input  logic [router_pkg::NUM_LANES-1:0] lane_ready
);

    // One-hot decode of the incoming destination, all zero when out of range
    logic [router_pkg::NUM_LANES-1:0] dest_hit;
    logic                             in_range;
    logic                             taken;
    logic                             accept;

    always_comb begin
        dest_hit = '0;
        for (int i = 0; i < router_pkg::NUM_LANES; i++) begin
            if (in_beat.dest == router_pkg::dest_t'(i)) begin
                dest_hit[i] = 1'b1;
            end
        end
    end

    assign in_range = |dest_hit;

    // The buffered sample leaves when its lane is ready
    assign taken = |(lane_valid & lane_ready);

    // Room for a new sample when the buffer is empty or draining this cycle
    assign in_ready = (lane_valid == '0) || taken;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= '0;
        end else begin
            if (accept) begin
                // An out-of-range sample loads all zeros, so nothing is buffered
                lane_valid <= dest_hit;
            end else if (taken) begin
                lane_valid <= '0;
            end
        end
    end

    // Payload only changes when a routable sample is captured
    always_ff @(posedge clock) begin
        if (accept && in_range) begin
            lane_beat <= in_beat;
        end
    end

    // The decode must never offer the same sample to two lanes
    a_lane_valid_onehot: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0(lane_valid)
    ) else $error("lane_valid is not one-hot: %b", lane_valid);

endmodule

// ==== tests/clock_gen.sv ====
// Clock and reset source for the router testbench.
// The clock has a 4 ns period. Reset is held low for the first
// four rising edges and released on the fourth.

`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/tb_frame_sum_router.sv ====
// Table-driven testbench for the frame-summing stream router.
// Each table row gives a destination, an end-of-frame flag and the
// out_ready level to present while that sample is offered. A model
// builds the expected frame results per lane, and a monitor pops them
// as results leave the DUT. One line is printed per test group.

`timescale 1ns/1ps

module tb_frame_sum_router;

    localparam int TABLE_LEN      = 38;
    localparam int TIMEOUT_CYCLES = 8 * TABLE_LEN + 100;

    typedef struct packed {
        logic [2:0]         test;
        router_pkg::dest_t  dest;
        logic               last;
        logic               ready;
    } entry_t;

    logic                     clock;
    logic                     rst_n;
    router_pkg::sample_beat_t in_beat;
    logic                     in_valid;
    logic                     in_ready;
    router_pkg::sum_beat_t    out_beat;
    logic                     out_valid;
    logic                     out_ready;

    entry_t                   table_mem [TABLE_LEN];
    int                       fill_count;
    integer                   seed;
    int                       errors;
    int                       checked;
    int                       test_errors_start;
    int                       test_checked_start;
    int                       cycles;
    int                       cur_test;

    // Expected results per lane, in frame order
    router_pkg::sum_beat_t    exp_q [router_pkg::NUM_LANES][$];
    router_pkg::sum_t         model_sum [router_pkg::NUM_LANES];
    router_pkg::count_t       model_count [router_pkg::NUM_LANES];

    // Output history for the back-pressure stability check
    logic                     prev_stalled;
    router_pkg::sum_beat_t    prev_beat;

    clock_gen clock_gen_i (
        .clock (clock),
        .rst_n (rst_n)
    );

    frame_sum_router frame_sum_router_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic add_entry(input int test, input int dest, input logic last, input logic ready);
        table_mem[fill_count].test  = 3'(test);
        table_mem[fill_count].dest  = router_pkg::dest_t'(dest);
        table_mem[fill_count].last  = last;
        table_mem[fill_count].ready = ready;
        fill_count++;
    endtask

    task automatic build_table();
        fill_count = 0;
        // Test 1 has one three-sample frame to lane 0
        add_entry(1, 0, 1'b0, 1'b1);
        add_entry(1, 0, 1'b0, 1'b1);
        add_entry(1, 0, 1'b1, 1'b1);
        // Test 2 interleaves frames over all four lanes
        add_entry(2, 0, 1'b0, 1'b1);
        add_entry(2, 1, 1'b0, 1'b1);
        add_entry(2, 2, 1'b0, 1'b1);
        add_entry(2, 3, 1'b0, 1'b1);
        add_entry(2, 0, 1'b1, 1'b1);
        add_entry(2, 1, 1'b0, 1'b1);
        add_entry(2, 1, 1'b1, 1'b1);
        add_entry(2, 2, 1'b1, 1'b1);
        add_entry(2, 3, 1'b1, 1'b1);
        add_entry(2, 0, 1'b0, 1'b1);
        add_entry(2, 0, 1'b1, 1'b1);
        add_entry(2, 3, 1'b0, 1'b1);
        add_entry(2, 3, 1'b1, 1'b1);
        // Test 3 mixes unroutable destinations into and between frames
        add_entry(3, 1, 1'b0, 1'b1);
        add_entry(3, 5, 1'b0, 1'b1);
        add_entry(3, 1, 1'b0, 1'b1);
        add_entry(3, 7, 1'b1, 1'b1);
        add_entry(3, 1, 1'b1, 1'b1);
        add_entry(3, 4, 1'b0, 1'b1);
        add_entry(3, 2, 1'b0, 1'b1);
        add_entry(3, 6, 1'b1, 1'b1);
        add_entry(3, 2, 1'b1, 1'b1);
        // Test 4 throttles the output with out_ready low on most rows
        add_entry(4, 0, 1'b1, 1'b0);
        add_entry(4, 1, 1'b1, 1'b0);
        add_entry(4, 2, 1'b0, 1'b1);
        add_entry(4, 2, 1'b1, 1'b0);
        add_entry(4, 3, 1'b1, 1'b0);
        add_entry(4, 0, 1'b1, 1'b1);
        add_entry(4, 1, 1'b1, 1'b0);
        // Test 5 sends one-sample frames back to back to lane 2
        add_entry(5, 2, 1'b1, 1'b1);
        add_entry(5, 2, 1'b1, 1'b1);
        add_entry(5, 2, 1'b1, 1'b0);
        add_entry(5, 2, 1'b1, 1'b1);
        add_entry(5, 2, 1'b1, 1'b0);
        add_entry(5, 2, 1'b1, 1'b1);
    endtask

    function automatic string test_name(input int t);
        case (t)
            1: return "single frame to lane 0";
            2: return "interleaved frames on all lanes";
            3: return "unroutable destinations dropped";
            4: return "output back-pressure";
            5: return "back-to-back one-sample frames";
            6: return "all expected results received";
            default: return "unnamed";
        endcase
    endfunction

    function automatic logic all_empty();
        for (int l = 0; l < router_pkg::NUM_LANES; l++) begin
            if (exp_q[l].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_missing();
        for (int l = 0; l < router_pkg::NUM_LANES; l++) begin
            if (exp_q[l].size() != 0) begin
                $display("results missing for lane %0d", l);
                errors++;
            end
        end
    endtask

    // Offers one sample, updates the model and returns on the accepting edge
    task automatic apply_entry(input entry_t e);
        router_pkg::sample_beat_t beat;
        router_pkg::sum_beat_t    exp_beat;
        int                       lane;
        beat.data = router_pkg::sample_t'($random(seed));
        beat.dest = e.dest;
        beat.last = e.last;
        lane = int'(e.dest);
        if (lane < router_pkg::NUM_LANES) begin
            model_sum[lane]   = model_sum[lane] + router_pkg::sum_t'(beat.data);
            model_count[lane] = model_count[lane] + router_pkg::count_t'(1);
            if (e.last) begin
                exp_beat.sum   = model_sum[lane];
                exp_beat.count = model_count[lane];
                exp_beat.lane  = router_pkg::lane_t'(lane);
                exp_q[lane].push_back(exp_beat);
                model_sum[lane]   = '0;
                model_count[lane] = '0;
            end
        end
        in_beat   <= beat;
        in_valid  <= 1'b1;
        out_ready <= e.ready;
        @(posedge clock);
        while (!in_ready) begin
            // Release the output so a stalled input can always drain
            out_ready <= 1'b1;
            @(posedge clock);
        end
    endtask

    task automatic finish_test(input int t);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (!all_empty()) begin
            @(posedge clock);
        end
        // A few idle cycles so a surplus result is still seen by the monitor
        repeat (8) @(posedge clock);
        $display("test %0d (%s): %0d results, %0d errors", t, test_name(t),
                 checked - test_checked_start, errors - test_errors_start);
        test_errors_start  = errors;
        test_checked_start = checked;
    endtask

    // Output monitor, sampling on the rising edge where values are settled
    always @(posedge clock) begin
        if (rst_n) begin
            if (prev_stalled) begin
                assert (out_valid) else begin
                    $display("out_valid dropped while out_ready was low");
                    errors++;
                end
                assert (out_beat == prev_beat) else begin
                    $display("mismatch out_beat: expected %h, got %h", prev_beat, out_beat);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q[out_beat.lane].size() == 0) begin
                    $display("unexpected result from lane %0d", out_beat.lane);
                    errors++;
                end else begin
                    prev_beat = exp_q[out_beat.lane].pop_front();
                    checked++;
                    assert (out_beat.sum == prev_beat.sum) else begin
                        $display("mismatch out_beat.sum: expected %h, got %h",
                                 prev_beat.sum, out_beat.sum);
                        errors++;
                    end
                    assert (out_beat.count == prev_beat.count) else begin
                        $display("mismatch out_beat.count: expected %h, got %h",
                                 prev_beat.count, out_beat.count);
                        errors++;
                    end
                end
            end
            prev_stalled = out_valid && !out_ready;
            prev_beat    = out_beat;
        end else begin
            prev_stalled = 1'b0;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout waiting for results");
        report_missing();
        $display("Regression failed");
        $finish;
    end

    initial begin
        in_beat            = '0;
        in_valid           = 1'b0;
        out_ready          = 1'b0;
        seed               = 32'h2cac8538;
        errors             = 0;
        checked            = 0;
        test_errors_start  = 0;
        test_checked_start = 0;
        prev_stalled       = 1'b0;
        for (int l = 0; l < router_pkg::NUM_LANES; l++) begin
            model_sum[l]   = '0;
            model_count[l] = '0;
        end
        build_table();

        @(posedge rst_n);
        @(posedge clock);
        assert (!out_valid) else begin
            $display("out_valid is high after reset");
            errors++;
        end

        cur_test = int'(table_mem[0].test);
        for (int n = 0; n < TABLE_LEN; n++) begin
            if (int'(table_mem[n].test) != cur_test) begin
                finish_test(cur_test);
                cur_test = int'(table_mem[n].test);
            end
            apply_entry(table_mem[n]);
        end
        finish_test(cur_test);

        report_missing();
        $display("test 6 (%s): %0d errors", test_name(6), errors - test_errors_start);
        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
